//--- Bender.yml
package:
  name: packet_encoder

sources:
  - design/enc_pkg.sv
  - design/enc_8b10b.sv
  - design/crc32_accum.sv
  - design/frame_sequencer.sv
  - design/packet_encoder.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_packet_encoder.sv

//--- design/crc32_accum.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_accum (
	input wire clk,
	input wire reset,
	input wire crc_clear,
	input wire byte_valid,
	input wire [enc_pkg::byte_w-1:0] data_byte,
	output logic [enc_pkg::crc_w-1:0] crc
);

	logic [enc_pkg::crc_w-1:0] rem_q;
	logic [enc_pkg::crc_w-1:0] rem_next;

	// One byte folded in LSB first
	always_comb begin
		rem_next = rem_q ^ {{(enc_pkg::crc_w - enc_pkg::byte_w){1'b0}}, data_byte};
		for (int i = 0; i < enc_pkg::byte_w; i++) begin
			if (rem_next[0]) begin
				rem_next = (rem_next >> 1) ^ enc_pkg::crc_poly_rev;
			end else begin
				rem_next = rem_next >> 1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rem_q <= enc_pkg::crc_init;
		end else if (crc_clear) begin
			rem_q <= enc_pkg::crc_init;
		end else if (byte_valid) begin
			rem_q <= rem_next;
		end
	end

	// Final inversion
	assign crc = ~rem_q;

endmodule

`default_nettype wire

//--- design/enc_8b10b.sv
`timescale 1ns/1ps
`default_nettype none

module enc_8b10b (
	input wire clk,
	input wire reset,
	input wire sym_valid,
	input wire [enc_pkg::sym_w-1:0] sym,
	input wire frame_start,
	output logic code_valid,
	output logic [enc_pkg::code_w-1:0] code,
	output logic start_flag
);

	// 5b/6b for negative RD, bit 0 carries line bit a
	function automatic logic [5:0] d6_neg(input logic [4:0] x);
		case (x)
			5'd0: d6_neg = 6'b111001;
			5'd1: d6_neg = 6'b101110;
			5'd2: d6_neg = 6'b101101;
			5'd3: d6_neg = 6'b100011;
			5'd4: d6_neg = 6'b101011;
			5'd5: d6_neg = 6'b100101;
			5'd6: d6_neg = 6'b100110;
			5'd7: d6_neg = 6'b000111;
			5'd8: d6_neg = 6'b100111;
			5'd9: d6_neg = 6'b101001;
			5'd10: d6_neg = 6'b101010;
			5'd11: d6_neg = 6'b001011;
			5'd12: d6_neg = 6'b101100;
			5'd13: d6_neg = 6'b001101;
			5'd14: d6_neg = 6'b001110;
			5'd15: d6_neg = 6'b111010;
			5'd16: d6_neg = 6'b110110;
			5'd17: d6_neg = 6'b110001;
			5'd18: d6_neg = 6'b110010;
			5'd19: d6_neg = 6'b010011;
			5'd20: d6_neg = 6'b110100;
			5'd21: d6_neg = 6'b010101;
			5'd22: d6_neg = 6'b010110;
			5'd23: d6_neg = 6'b010111;
			5'd24: d6_neg = 6'b110011;
			5'd25: d6_neg = 6'b011001;
			5'd26: d6_neg = 6'b011010;
			5'd27: d6_neg = 6'b011011;
			5'd28: d6_neg = 6'b011100;
			5'd29: d6_neg = 6'b011101;
			5'd30: d6_neg = 6'b011110;
			default: d6_neg = 6'b110101;
		endcase
	endfunction

	// 3b/4b primary forms for negative RD, bit 0 carries line bit f
	function automatic logic [3:0] d4_neg(input logic [2:0] y);
		case (y)
			3'd0: d4_neg = 4'b1101;
			3'd1: d4_neg = 4'b1001;
			3'd2: d4_neg = 4'b1010;
			3'd3: d4_neg = 4'b0011;
			3'd4: d4_neg = 4'b1011;
			3'd5: d4_neg = 4'b0101;
			3'd6: d4_neg = 4'b0110;
			default: d4_neg = 4'b0111;
		endcase
	endfunction

	logic rd;  // 0 means RD-, 1 means RD+
	logic [4:0] x_val;
	logic [2:0] y_val;
	logic [5:0] d6_n;
	logic [5:0] d6;
	logic rd_mid;
	logic alt7;
	logic [3:0] d4_n;
	logic [3:0] d4;
	logic [enc_pkg::code_w-1:0] k_n;
	logic k_ok;
	logic sym_ok;
	logic [enc_pkg::code_w-1:0] code_next;

	assign x_val = sym[4:0];
	assign y_val = sym[7:5];

	// Unbalanced codes and D.7 invert under RD+
	assign d6_n = d6_neg(x_val);
	assign d6 = (rd && ($countones(d6_n) != 3 || x_val == 5'd7)) ? ~d6_n : d6_n;
	assign rd_mid = rd ^ ($countones(d6) != 3);

	// Alternate D.x.7 avoids a run of five
	assign alt7 = (y_val == 3'd7) &&
		((!rd_mid && (x_val == 5'd17 || x_val == 5'd18 || x_val == 5'd20)) ||
		(rd_mid && (x_val == 5'd11 || x_val == 5'd13 || x_val == 5'd14)));
	assign d4_n = alt7 ? 4'b1110 : d4_neg(y_val);
	assign d4 = (rd_mid && (y_val == 3'd0 || y_val == 3'd3 || y_val == 3'd4 ||
		y_val == 3'd7)) ? ~d4_n : d4_n;

	// Control codewords for RD-, RD+ is the full complement
	always_comb begin
		k_ok = 1'b1;
		case (sym[7:0])
			enc_pkg::k28_0: k_n = 10'b0010111100;
			enc_pkg::k28_1: k_n = 10'b1001111100;
			enc_pkg::k28_2: k_n = 10'b1010111100;
			enc_pkg::k28_3: k_n = 10'b1100111100;
			enc_pkg::k28_4: k_n = 10'b0100111100;
			enc_pkg::k28_5: k_n = 10'b0101111100;
			enc_pkg::k28_6: k_n = 10'b0110111100;
			enc_pkg::k28_7: k_n = 10'b0001111100;
			enc_pkg::k23_7: k_n = 10'b0001010111;
			enc_pkg::k27_7: k_n = 10'b0001011011;
			enc_pkg::k29_7: k_n = 10'b0001011101;
			enc_pkg::k30_7: k_n = 10'b0001011110;
			default: begin
				k_n = '0;
				k_ok = 1'b0;
			end
		endcase
	end

	assign sym_ok = !sym[enc_pkg::sym_w-1] || k_ok;
	assign code_next = sym[enc_pkg::sym_w-1] ? (rd ? ~k_n : k_n) : {d4, d6};

	always_ff @(posedge clk) begin
		if (reset) begin
			code_valid <= 1'b0;
			start_flag <= 1'b0;
			rd <= 1'b0;
		end else begin
			code_valid <= sym_valid && sym_ok;
			start_flag <= sym_valid && frame_start;
			// RD flips on any unbalanced codeword
			if (sym_valid && sym_ok) begin
				rd <= rd ^ ($countones(code_next) != 5);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sym_valid && sym_ok) begin
			code <= code_next;
		end
	end

endmodule

`default_nettype wire

//--- design/enc_pkg.sv
`default_nettype none

package enc_pkg;

	// Symbol and codeword widths
	localparam int sym_w = 9;
	localparam int byte_w = 8;
	localparam int code_w = 10;
	localparam int crc_w = 32;

	// Frame layout
	localparam int preamble_len = 4;
	localparam int crc_bytes = 4;

	// Supported control bytes, K flag not included
	localparam logic [byte_w-1:0] k28_0 = 8'h1C;
	localparam logic [byte_w-1:0] k28_1 = 8'h3C;
	localparam logic [byte_w-1:0] k28_2 = 8'h5C;
	localparam logic [byte_w-1:0] k28_3 = 8'h7C;
	localparam logic [byte_w-1:0] k28_4 = 8'h9C;
	localparam logic [byte_w-1:0] k28_5 = 8'hBC;
	localparam logic [byte_w-1:0] k28_6 = 8'hDC;
	localparam logic [byte_w-1:0] k28_7 = 8'hFC;
	localparam logic [byte_w-1:0] k23_7 = 8'hF7;
	localparam logic [byte_w-1:0] k27_7 = 8'hFB;
	localparam logic [byte_w-1:0] k29_7 = 8'hFD;
	localparam logic [byte_w-1:0] k30_7 = 8'hFE;

	// Framing symbols with the K flag in bit 8
	localparam logic [sym_w-1:0] sym_k28_1 = {1'b1, k28_1};
	localparam logic [sym_w-1:0] sym_k23_7 = {1'b1, k23_7};
	localparam logic [sym_w-1:0] sym_k28_5 = {1'b1, k28_5};

	// Reflected CRC-32, all-ones seed
	localparam logic [crc_w-1:0] crc_poly_rev = 32'hEDB88320;
	localparam logic [crc_w-1:0] crc_init = 32'hFFFFFFFF;

	// Frame sequencer states
	typedef enum logic [2:0] {
		idle,
		preamble,
		data,
		trailer,
		close
	} frame_state_t;

endpackage

`default_nettype wire

//--- design/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer (
	input wire clk,
	input wire reset,
	input wire pushin,
	input wire startin,
	input wire [enc_pkg::sym_w-1:0] datain,
	input wire [enc_pkg::crc_w-1:0] crc,
	output logic crc_clear,
	output logic byte_valid,
	output logic sym_valid,
	output logic [enc_pkg::sym_w-1:0] sym,
	output logic frame_start
);

	enc_pkg::frame_state_t state_q;
	enc_pkg::frame_state_t state_d;

	// Shared by the preamble count and the trailer byte index
	logic [1:0] cnt_q;
	logic [1:0] cnt_d;
	logic [enc_pkg::byte_w-1:0] crc_byte;

	// Trailer goes out lowest byte first
	assign crc_byte = crc[{cnt_q, 3'b000} +: enc_pkg::byte_w];

	always_comb begin
		state_d = state_q;
		cnt_d = cnt_q;
		sym_valid = 1'b0;
		sym = datain;
		frame_start = 1'b0;
		crc_clear = 1'b0;
		byte_valid = 1'b0;
		case (state_q)
			enc_pkg::idle: begin
				if (pushin && startin && datain == enc_pkg::sym_k28_1) begin
					sym_valid = 1'b1;
					frame_start = 1'b1;
					crc_clear = 1'b1;
					cnt_d = '0;
					state_d = enc_pkg::preamble;
				end
			end
			enc_pkg::preamble: begin
				if (pushin) begin
					if (datain == enc_pkg::sym_k28_1) begin
						sym_valid = 1'b1;
						cnt_d = cnt_q + 2'd1;
						// Fourth K28.1 completes the preamble
						if (cnt_q == enc_pkg::preamble_len - 2) begin
							cnt_d = '0;
							state_d = enc_pkg::data;
						end
					end else begin
						// Broken preamble, drop the frame silently
						state_d = enc_pkg::idle;
					end
				end
			end
			enc_pkg::data: begin
				if (pushin) begin
					sym_valid = 1'b1;
					byte_valid = !datain[enc_pkg::sym_w-1];
					if (datain == enc_pkg::sym_k23_7) begin
						cnt_d = '0;
						state_d = enc_pkg::trailer;
					end
				end
			end
			enc_pkg::trailer: begin
				sym_valid = 1'b1;
				sym = {1'b0, crc_byte};
				cnt_d = cnt_q + 2'd1;
				if (cnt_q == enc_pkg::crc_bytes - 1) begin
					cnt_d = '0;
					state_d = enc_pkg::close;
				end
			end
			enc_pkg::close: begin
				sym_valid = 1'b1;
				sym = enc_pkg::sym_k28_5;
				state_d = enc_pkg::idle;
			end
			default: begin
				state_d = enc_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= enc_pkg::idle;
			cnt_q <= '0;
		end else begin
			state_q <= state_d;
			cnt_q <= cnt_d;
		end
	end

endmodule

`default_nettype wire

//--- design/packet_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module packet_encoder (
	input wire clk,
	input wire reset,
	input wire pushin,
	input wire startin,
	input wire [enc_pkg::sym_w-1:0] datain,
	output logic pushout,
	output logic startout,
	output logic [enc_pkg::code_w-1:0] dataout
);

	logic crc_clear;
	logic byte_valid;
	logic [enc_pkg::crc_w-1:0] crc;
	logic sym_valid;
	logic [enc_pkg::sym_w-1:0] sym;
	logic frame_start;

	frame_sequencer u_seq (
		.clk(clk),
		.reset(reset),
		.pushin(pushin),
		.startin(startin),
		.datain(datain),
		.crc(crc),
		.crc_clear(crc_clear),
		.byte_valid(byte_valid),
		.sym_valid(sym_valid),
		.sym(sym),
		.frame_start(frame_start)
	);

	// CRC sees the raw input byte, the sequencer qualifies it
	crc32_accum u_crc (
		.clk(clk),
		.reset(reset),
		.crc_clear(crc_clear),
		.byte_valid(byte_valid),
		.data_byte(datain[enc_pkg::byte_w-1:0]),
		.crc(crc)
	);

	enc_8b10b u_enc (
		.clk(clk),
		.reset(reset),
		.sym_valid(sym_valid),
		.sym(sym),
		.frame_start(frame_start),
		.code_valid(pushout),
		.code(dataout),
		.start_flag(startout)
	);

endmodule

`default_nettype wire

//--- src.f
+incdir+testbench
design/enc_pkg.sv
design/enc_8b10b.sv
design/crc32_accum.sv
design/frame_sequencer.sv
design/packet_encoder.sv
testbench/tb_packet_encoder.sv

//--- testbench/tb_ref_model.svh
// Standard 8b/10b tables in abcdei / fghj line order, RD- column
function automatic logic [5:0] sub6_line(input logic [4:0] x);
	logic [5:0] t [0:31];
	t = '{6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001,
		6'b011001, 6'b111000, 6'b111001, 6'b100101, 6'b010101, 6'b110100,
		6'b001101, 6'b101100, 6'b011100, 6'b010111, 6'b011011, 6'b100011,
		6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
		6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110,
		6'b011110, 6'b101011};
	return t[x];
endfunction

function automatic logic [3:0] sub4_line(input logic [2:0] y);
	logic [3:0] t [0:7];
	t = '{4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};
	return t[y];
endfunction

// Line bit a lands in bit 0, bit j in bit 9
function automatic logic [9:0] line_to_word(input logic [5:0] abcdei, input logic [3:0] fghj);
	logic [9:0] w;
	for (int i = 0; i < 6; i++) begin
		w[i] = abcdei[5-i];
	end
	for (int i = 0; i < 4; i++) begin
		w[6+i] = fghj[3-i];
	end
	return w;
endfunction

// Control word for RD-, zero when the byte is not a supported K code
function automatic logic [9:0] control_word(input logic [7:0] b);
	case (b)
		8'h1C: return line_to_word(6'b001111, 4'b0100);
		8'h3C: return line_to_word(6'b001111, 4'b1001);
		8'h5C: return line_to_word(6'b001111, 4'b0101);
		8'h7C: return line_to_word(6'b001111, 4'b0011);
		8'h9C: return line_to_word(6'b001111, 4'b0010);
		8'hBC: return line_to_word(6'b001111, 4'b1010);
		8'hDC: return line_to_word(6'b001111, 4'b0110);
		8'hFC: return line_to_word(6'b001111, 4'b1000);
		8'hF7: return line_to_word(6'b111010, 4'b1000);
		8'hFB: return line_to_word(6'b110110, 4'b1000);
		8'hFD: return line_to_word(6'b101110, 4'b1000);
		8'hFE: return line_to_word(6'b011110, 4'b1000);
		default: return 10'd0;
	endcase
endfunction

function automatic logic [9:0] model_encode(input logic [8:0] s, inout logic rd_pos);
	logic [5:0] a6;
	logic [3:0] f4;
	logic mid;
	logic [9:0] w;
	if (s[8]) begin
		w = control_word(s[7:0]);
		if (rd_pos) begin
			w = ~w;
		end
	end else begin
		a6 = sub6_line(s[4:0]);
		if (rd_pos && ($countones(a6) != 3 || s[4:0] == 5'd7)) begin
			a6 = ~a6;
		end
		mid = rd_pos ^ ($countones(a6) != 3);
		f4 = sub4_line(s[7:5]);
		if (s[7:5] == 3'd7 && ((!mid && (s[4:0] == 17 || s[4:0] == 18 || s[4:0] == 20)) ||
			(mid && (s[4:0] == 11 || s[4:0] == 13 || s[4:0] == 14)))) begin
			f4 = 4'b0111;
		end
		if (mid && ($countones(f4) != 2 || s[7:5] == 3'd3)) begin
			f4 = ~f4;
		end
		w = line_to_word(a6, f4);
	end
	rd_pos = rd_pos ^ ($countones(w) != 5);
	return w;
endfunction

// Reflected CRC-32, one byte
function automatic logic [31:0] crc_byte_step(input logic [31:0] c, input logic [7:0] b);
	c = c ^ {24'd0, b};
	for (int i = 0; i < 8; i++) begin
		c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
	end
	return c;
endfunction

//--- testbench/tb_packet_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_packet_encoder;

	localparam int max_cycles = 3000;

	logic clk;
	logic reset;
	logic pushin;
	logic startin;
	logic [8:0] datain;
	wire pushout;
	wire startout;
	wire [9:0] dataout;

	logic [10:0] expect_q[$];
	logic [8:0] frame_body[$];
	logic model_rd;
	logic [31:0] model_crc;
	int cycle;
	int last_out_cycle;
	int line_disp;
	int errors;
	int err_start;
	int tests_passed;
	int tests_failed;
	int seed_ret;

	`include "tb_ref_model.svh"

	packet_encoder uut (
		.clk(clk),
		.reset(reset),
		.pushin(pushin),
		.startin(startin),
		.datain(datain),
		.pushout(pushout),
		.startout(startout),
		.dataout(dataout)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle++;
		if (cycle >= max_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// Outputs are registered on posedge, so the falling edge sees them settled
	always @(negedge clk) begin
		logic [10:0] exp_word;
		if (!reset) begin
			if (pushout) begin
				last_out_cycle = cycle;
				if (expect_q.size() == 0) begin
					errors++;
					$display("Unexpected codeword %h at %0t while none was expected",
						dataout, $time);
				end else begin
					exp_word = expect_q.pop_front();
					check_equal(dataout, exp_word[9:0], "codeword");
					check_equal(startout, exp_word[10], "startout");
				end
				check_equal($countones(dataout) >= 4 && $countones(dataout) <= 6, 1,
					"ones count in range");
				line_disp = line_disp + 2 * $countones(dataout) - 10;
				check_equal(line_disp == 1 || line_disp == -1, 1, "line running disparity");
			end else begin
				check_equal(pushout, 0, "pushout low");
				check_equal(startout, 0, "startout without pushout");
			end
		end
	end

	task automatic push_sym(input logic [8:0] s, input logic start);
		@(negedge clk);
		pushin = 1'b1;
		startin = start;
		datain = s;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			pushin = 1'b0;
			startin = 1'b0;
		end
	endtask

	task automatic expect_sym(input logic [8:0] s, input logic start);
		if (!s[8] || control_word(s[7:0]) != 10'd0) begin
			expect_q.push_back({start, model_encode(s, model_rd)});
		end
	endtask

	task automatic wait_drain();
		while (expect_q.size() > 0) begin
			@(posedge clk);
		end
		idle_cycles(2);
	endtask

	// Preamble, frame_body, end symbol, then the CRC trailer and comma
	task automatic send_frame(input int gap_pct);
		int end_cycle;
		logic [31:0] fin;
		model_crc = 32'hFFFFFFFF;
		for (int i = 0; i < 4; i++) begin
			if (i > 0 && $urandom_range(99) < gap_pct) begin
				idle_cycles(1);
			end
			push_sym(9'h13C, i == 0);
			expect_sym(9'h13C, i == 0);
		end
		foreach (frame_body[i]) begin
			if ($urandom_range(99) < gap_pct) begin
				idle_cycles(1);
			end
			push_sym(frame_body[i], 1'b0);
			expect_sym(frame_body[i], 1'b0);
			if (!frame_body[i][8]) begin
				model_crc = crc_byte_step(model_crc, frame_body[i][7:0]);
			end
		end
		push_sym(9'h1F7, 1'b0);
		end_cycle = cycle;
		expect_sym(9'h1F7, 1'b0);
		fin = ~model_crc;
		for (int b = 0; b < 4; b++) begin
			expect_sym({1'b0, fin[8*b +: 8]}, 1'b0);
		end
		expect_sym(9'h1BC, 1'b0);
		idle_cycles(6);
		wait_drain();
		check_equal(last_out_cycle - end_cycle, 6, "cycles from end symbol to K28.5");
	endtask

	task automatic begin_test();
		err_start = errors;
		frame_body.delete();
	endtask

	task automatic end_test(input string name);
		if (errors == err_start) begin
			tests_passed++;
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - err_start);
		end
	endtask

	task automatic test_reset_idle();
		begin_test();
		idle_cycles(10);
		end_test("reset idle");
	endtask

	task automatic test_short_frame();
		begin_test();
		frame_body = '{9'h012, 9'h0A5, 9'h0FF};
		send_frame(0);
		end_test("short frame");
	endtask

	task automatic test_all_bytes();
		begin_test();
		for (int i = 0; i < 256; i++) begin
			frame_body.push_back({1'b0, i[7:0]});
		end
		send_frame(0);
		end_test("all data bytes");
	endtask

	task automatic test_controls();
		begin_test();
		frame_body = '{9'h11C, 9'h13C, 9'h15C, 9'h055, 9'h17C, 9'h19C, 9'h100, 9'h1BC,
			9'h1DC, 9'h1FC, 9'h1AB, 9'h1FB, 9'h1FD, 9'h1FE, 9'h0F1};
		send_frame(0);
		end_test("control codes");
	endtask

	task automatic test_bad_preamble();
		begin_test();
		push_sym(9'h13C, 1'b1);
		expect_sym(9'h13C, 1'b1);
		push_sym(9'h13C, 1'b0);
		expect_sym(9'h13C, 1'b0);
		// Data byte inside the preamble, then stray traffic while idle
		push_sym(9'h042, 1'b0);
		push_sym(9'h013, 1'b0);
		push_sym(9'h1F7, 1'b0);
		idle_cycles(3);
		wait_drain();
		frame_body = '{9'h0C3, 9'h07E};
		send_frame(0);
		end_test("bad preamble");
	endtask

	task automatic test_random_frames();
		int len;
		begin_test();
		for (int f = 0; f < 8; f++) begin
			frame_body.delete();
			len = $urandom_range(24, 1);
			for (int i = 0; i < len; i++) begin
				frame_body.push_back({1'b0, 8'($urandom)});
			end
			send_frame(25);
		end
		end_test("random frames");
	endtask

	initial begin
		seed_ret = $urandom(32'h618957c9);
		reset = 1'b1;
		pushin = 1'b0;
		startin = 1'b0;
		datain = 9'd0;
		model_rd = 1'b0;
		model_crc = 32'hFFFFFFFF;
		cycle = 0;
		last_out_cycle = 0;
		line_disp = -1;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset_idle();
		test_short_frame();
		test_all_bytes();
		test_controls();
		test_bad_preamble();
		test_random_frames();
		$display("Tests passed: %0d, tests failed: %0d, errors: %0d",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0 && expect_q.size() == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
